// ==== rtl/mbu_config.svh ====
/*
 * Memory Bank Unit configuration
 * Unit address codes, slot count, context width and the
 * front-panel ROM default used while the unit is disabled
 */

`ifndef MBU_CONFIG_SVH
`define MBU_CONFIG_SVH

// Bank register positions per context
`define MBU_SLOTS        8

// Context register width, sets slot memory depth
`define MBU_CTX_BITS     8

// Read and write unit address codes
`define MBU_UA_MBN       5'h1B   // Bank register picked by IR
`define MBU_UA_MBP       5'h1C   // Bank register 0
`define MBU_UA_CTX0      5'h1D   // Context register
`define MBU_UA_CTX1      5'h1E   // Context register, alias

// Top three bits shared by the four AR write codes
`define MBU_UA_AR_HI     3'b001

// Upper address byte forced when ROM is selected
`define MBU_ROM_DEFAULT  8'h80

`endif

// ==== rtl/mbu_pkg.sv ====
/*
 * Memory Bank Unit types
 * Vector typedefs shared by the bank unit RTL and its testbench
 */

`include "mbu_config.svh"

package mbu_pkg;

   ////////////////////////////////////////////////////////////
   // Data
   ////////////////////////////////////////////////////////////

   // Extended address byte held in one bank register
   typedef logic [7:0] bank_t;

   // Context number, also the slot memory row
   typedef logic [`MBU_CTX_BITS-1:0] ctx_t;

   ////////////////////////////////////////////////////////////
   // Addressing
   ////////////////////////////////////////////////////////////

   // Bank register position within a context
   typedef logic [2:0] slot_idx_t;

   // Processor read or write unit code
   typedef logic [4:0] unit_addr_t;

endpackage

// ==== rtl/mbu_decoder.sv ====
/*
 * Memory Bank Unit decoder
 * Turns the read and write unit addresses into slot write enables,
 * the context load, the AR write flag and the read source selects.
 * Also picks the slot that drives aext and the bank read path.
 */

`timescale 1ns/1ns

`include "mbu_config.svh"

module mbu_decoder (
   input  mbu_pkg::unit_addr_t     raddr,     // Read unit
   input  mbu_pkg::unit_addr_t     waddr,     // Write unit
   input  mbu_pkg::slot_idx_t      ir,        // IR low bits
   input  logic                    ir_idx,    // Index AR writes by IR
   output logic [`MBU_SLOTS-1:0]   slot_wr,   // One-hot slot write
   output logic                    ctx_wr,    // Load context register
   output logic                    mbn_wr,    // MBn write, enables unit
   output logic                    war,       // AR write in progress
   output logic                    rd_bank,   // MBn or MBP read
   output logic                    rd_ctx,    // CTX read
   output mbu_pkg::slot_idx_t      sel_slot   // Slot for aext and reads
);

   // Individual code matches
   logic                wr_mbn;
   logic                wr_mbp;
   logic                wr_ar;
   logic                rd_mbn;
   logic                rd_mbp;
   mbu_pkg::slot_idx_t  wr_slot;               // Target of a bank write

   ////////////////////////////////////////////////////////////
   // Address compare
   ////////////////////////////////////////////////////////////

   assign wr_mbn = (waddr == `MBU_UA_MBN);
   assign wr_mbp = (waddr == `MBU_UA_MBP);
   assign wr_ar  = (waddr[4:2] == `MBU_UA_AR_HI);   // 001xx

   assign rd_mbn = (raddr == `MBU_UA_MBN);
   assign rd_mbp = (raddr == `MBU_UA_MBP);

   // Two codes map onto the one context register
   assign ctx_wr = (waddr == `MBU_UA_CTX0) || (waddr == `MBU_UA_CTX1);
   assign rd_ctx = (raddr == `MBU_UA_CTX0) || (raddr == `MBU_UA_CTX1);

   assign rd_bank = rd_mbn | rd_mbp;
   assign mbn_wr  = wr_mbn;
   assign war     = wr_ar;

   ////////////////////////////////////////////////////////////
   // Slot index for aext and bank reads
   ////////////////////////////////////////////////////////////

   // AR writes take priority since aext feeds the address register
   always_comb begin
      if (wr_ar) begin
         if (ir_idx) begin
            sel_slot = ir;                       // Indexed by instruction
         end else begin
            sel_slot = {1'b0, waddr[1:0]};      // Fixed by AR code
         end
      end else if (rd_mbn) begin
         sel_slot = ir;
      end else begin
         sel_slot = '0;                          // MBP and idle
      end
   end

   ////////////////////////////////////////////////////////////
   // Bank write enables
   ////////////////////////////////////////////////////////////

   // MBn writes go to the IR slot and MBP writes to slot 0
   assign wr_slot = wr_mbn ? ir : '0;

   always_comb begin
      slot_wr = '0;
      for (int i = 0; i < `MBU_SLOTS; i++) begin
         slot_wr[i] = (wr_mbn || wr_mbp) && (wr_slot == mbu_pkg::slot_idx_t'(i));
      end
   end

endmodule

// ==== rtl/mbu_bank_slot.sv ====
/*
 * Memory Bank Unit slot
 * One bank register position, held for every context as a
 * byte-wide memory. Written on the clock edge, read asynchronously.
 */

`timescale 1ns/1ns

`include "mbu_config.svh"

module mbu_bank_slot (
   input  logic            clk4,     // Write strobe, rising edge
   input  logic            wr,       // Write this slot
   input  mbu_pkg::ctx_t   ctx,      // Current context selects the row
   input  mbu_pkg::bank_t  d,        // Write data from IBUS
   output mbu_pkg::bank_t  bank_q    // Row for the current context
);

   // One row per context number
   localparam int DEPTH = 1 << `MBU_CTX_BITS;

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////

   // Contents are undefined at power-on like the SRAM
   mbu_pkg::bank_t mem [DEPTH];

   always_ff @(posedge clk4) begin
      if (wr) begin
         mem[ctx] <= d;                  // Visible on the next cycle
      end
   end

   ////////////////////////////////////////////////////////////
   // Read
   ////////////////////////////////////////////////////////////

   // Flow-through read so aext follows a context change at once
   assign bank_q = mem[ctx];

endmodule

// ==== rtl/mbu_output_select.sv ====
/*
 * Memory Bank Unit output select
 * Holds the unit enable flop, picks the bank register that drives
 * aext, applies the front-panel default while disabled, and
 * steers bank or context data onto the IBUS read path.
 */

`timescale 1ns/1ns

`include "mbu_config.svh"

module mbu_output_select (
   input  logic                                clk4,        // Write strobe, rising edge
   input  logic                                rst_n,       // Async reset, active low
   input  logic                                mbn_wr,      // First MBn write enables
   input  logic                                rd_bank,     // MBn or MBP read
   input  logic                                rd_ctx,      // CTX read
   input  mbu_pkg::slot_idx_t                  sel_slot,    // Slot to present
   input  mbu_pkg::bank_t [`MBU_SLOTS-1:0]     slot_q,      // All slots, current context
   input  mbu_pkg::ctx_t                       ctx,         // Context register
   input  logic                                fp_ram_rom,  // 1 selects ROM
   output mbu_pkg::bank_t                      aext,        // Extended address byte
   output mbu_pkg::bank_t                      ibus_out,    // Read data
   output logic                                ibus_oe      // Read data valid
);

   logic             en;            // Unit enabled
   mbu_pkg::bank_t   fp_default;    // Power-on address byte
   mbu_pkg::bank_t   slot_sel_q;    // Selected slot contents

   ////////////////////////////////////////////////////////////
   // Enable flop
   ////////////////////////////////////////////////////////////

   // Cleared by reset, set for good by the first MBn write
   always_ff @(posedge clk4 or negedge rst_n) begin
      if (!rst_n) begin
         en <= 1'b0;
      end else if (mbn_wr) begin
         en <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Extended address
   ////////////////////////////////////////////////////////////

   // Boot from ROM at 80xxxx or RAM at 00xxxx
   assign fp_default = fp_ram_rom ? `MBU_ROM_DEFAULT : '0;

   assign slot_sel_q = slot_q[sel_slot];

   // Default stands in for the register file until enabled
   assign aext = en ? slot_sel_q : fp_default;

   ////////////////////////////////////////////////////////////
   // IBUS read path
   ////////////////////////////////////////////////////////////

   // Bank reads share the aext path, as on the board
   always_comb begin
      if (rd_ctx) begin
         ibus_out = mbu_pkg::bank_t'(ctx);
      end else begin
         ibus_out = aext;
      end
   end

   assign ibus_oe = rd_bank | rd_ctx;   // Drive only on a unit read

endmodule

// ==== rtl/mbu.sv ====
/*
 * Memory Bank Unit
 * Eight bank registers per context supply the upper address byte
 * for extended addressing. Holds the context register and ties the
 * decoder, the slot memories and the output select together.
 */

`timescale 1ns/1ns

`include "mbu_config.svh"

module mbu (
   input  logic                 clk4,        // Write strobe, rising edge
   input  logic                 rst_n,       // Async reset, active low
   input  mbu_pkg::unit_addr_t  raddr,       // Read unit
   input  mbu_pkg::unit_addr_t  waddr,       // Write unit
   input  mbu_pkg::bank_t       ibus_in,     // IBUS low byte in
   input  mbu_pkg::slot_idx_t   ir,          // IR low bits
   input  logic                 ir_idx,      // Index AR writes by IR
   input  logic                 fp_ram_rom,  // Front panel, 1 for ROM
   output mbu_pkg::bank_t       ibus_out,    // IBUS low byte out
   output logic                 ibus_oe,     // IBUS drive level
   output mbu_pkg::bank_t       aext,        // Extended address byte
   output logic                 war          // AR write flag
);

   logic [`MBU_SLOTS-1:0]               slot_wr;
   logic                                ctx_wr;
   logic                                mbn_wr;
   logic                                rd_bank;
   logic                                rd_ctx;
   mbu_pkg::slot_idx_t                  sel_slot;
   mbu_pkg::ctx_t                       ctx;
   mbu_pkg::bank_t [`MBU_SLOTS-1:0]     slot_q;

   ////////////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////////////

   mbu_decoder u_decoder (
      .raddr    (raddr),
      .waddr    (waddr),
      .ir       (ir),
      .ir_idx   (ir_idx),
      .slot_wr  (slot_wr),
      .ctx_wr   (ctx_wr),
      .mbn_wr   (mbn_wr),
      .war      (war),
      .rd_bank  (rd_bank),
      .rd_ctx   (rd_ctx),
      .sel_slot (sel_slot)
   );

   // Context register, starts in context 0
   always_ff @(posedge clk4 or negedge rst_n) begin
      if (!rst_n) begin
         ctx <= '0;
      end else if (ctx_wr) begin
         ctx <= mbu_pkg::ctx_t'(ibus_in);
      end
   end

   ////////////////////////////////////////////////////////////
   // Bank register file
   ////////////////////////////////////////////////////////////

   for (genvar g = 0; g < `MBU_SLOTS; g++) begin : g_slot
      mbu_bank_slot u_slot (
         .clk4   (clk4),
         .wr     (slot_wr[g]),
         .ctx    (ctx),
         .d      (ibus_in),
         .bank_q (slot_q[g])
      );
   end

   // Enable, default byte and read steering
   mbu_output_select u_output_select (
      .clk4       (clk4),
      .rst_n      (rst_n),
      .mbn_wr     (mbn_wr),
      .rd_bank    (rd_bank),
      .rd_ctx     (rd_ctx),
      .sel_slot   (sel_slot),
      .slot_q     (slot_q),
      .ctx        (ctx),
      .fp_ram_rom (fp_ram_rom),
      .aext       (aext),
      .ibus_out   (ibus_out),
      .ibus_oe    (ibus_oe)
   );

endmodule

// ==== test/mbu_tb.sv ====
/*
 * Memory Bank Unit testbench
 * Directed tests for the power-on default, the context register,
 * bank access through MBn and MBP, AR write slot selection and
 * context isolation, checked against a reference model
 */

`timescale 1ns/1ns

`include "mbu_config.svh"

module mbu_tb;

   localparam mbu_pkg::unit_addr_t IDLE = 5'h00;   // Matches no unit code
   localparam int TIMEOUT_CYCLES = 2000;           // Well above the full test length

   logic                  clk4;
   logic                  rst_n;
   mbu_pkg::unit_addr_t   raddr;
   mbu_pkg::unit_addr_t   waddr;
   mbu_pkg::bank_t        ibus_in;
   mbu_pkg::slot_idx_t    ir;
   logic                  ir_idx;
   logic                  fp_ram_rom;
   mbu_pkg::bank_t        ibus_out;
   logic                  ibus_oe;
   mbu_pkg::bank_t        aext;
   logic                  war;

   // Reference model
   mbu_pkg::bank_t        model_bank [1 << `MBU_CTX_BITS][`MBU_SLOTS];
   mbu_pkg::ctx_t         model_ctx;
   logic                  model_en;
   int                    cycle_count;

   mbu u_dut (
      .clk4       (clk4),
      .rst_n      (rst_n),
      .raddr      (raddr),
      .waddr      (waddr),
      .ibus_in    (ibus_in),
      .ir         (ir),
      .ir_idx     (ir_idx),
      .fp_ram_rom (fp_ram_rom),
      .ibus_out   (ibus_out),
      .ibus_oe    (ibus_oe),
      .aext       (aext),
      .war        (war)
   );

   always #2 clk4 = ~clk4;   // 4 ns period

   // Run limit
   always @(posedge clk4) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAIL");
         $fatal(1, "run stopped by cycle limit");
      end
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic check(input string name, input mbu_pkg::bank_t actual,
                        input mbu_pkg::bank_t expected);
      if (actual !== expected) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
         $display("TEST FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // Expected aext for a slot in the current model state
   function automatic mbu_pkg::bank_t model_aext(input mbu_pkg::slot_idx_t slot);
      if (!model_en) begin
         return fp_ram_rom ? `MBU_ROM_DEFAULT : 8'h00;   // Front-panel default
      end else begin
         return model_bank[model_ctx][slot];
      end
   endfunction

   task automatic next_drive();
      @(posedge clk4);
      #1;                                   // Drive point after the edge
   endtask

   task automatic apply_idle();
      raddr  = IDLE;
      waddr  = IDLE;
      ir_idx = 1'b0;
   endtask

   // One write cycle, model follows the same edge
   task automatic write_unit(input mbu_pkg::unit_addr_t addr, input mbu_pkg::bank_t data,
                             input mbu_pkg::slot_idx_t slot);
      raddr   = IDLE;
      waddr   = addr;
      ibus_in = data;
      ir      = slot;
      if (addr == `MBU_UA_MBN) begin
         model_bank[model_ctx][slot] = data;
         model_en = 1'b1;                   // First MBn write enables
      end else if (addr == `MBU_UA_MBP) begin
         model_bank[model_ctx][3'd0] = data;
      end else if (addr == `MBU_UA_CTX0 || addr == `MBU_UA_CTX1) begin
         model_ctx = mbu_pkg::ctx_t'(data);
      end
      #1;
      check("war", mbu_pkg::bank_t'(war), 8'h00);          // Not an AR write
      check("ibus_oe", mbu_pkg::bank_t'(ibus_oe), 8'h00);  // No read this cycle
      next_drive();
      apply_idle();
   endtask

   task automatic read_unit(input mbu_pkg::unit_addr_t addr, input mbu_pkg::slot_idx_t slot,
                            input mbu_pkg::bank_t expected);
      raddr = addr;
      waddr = IDLE;
      ir    = slot;
      #1;                                   // Let the read path settle
      check("ibus_oe", mbu_pkg::bank_t'(ibus_oe), 8'h01);
      check("war", mbu_pkg::bank_t'(war), 8'h00);
      check("ibus_out", ibus_out, expected);
      next_drive();
      apply_idle();
   endtask

   // Idle levels and aext with no access
   task automatic check_idle();
      apply_idle();
      #1;
      check("ibus_oe", mbu_pkg::bank_t'(ibus_oe), 8'h00);
      check("war", mbu_pkg::bank_t'(war), 8'h00);
      check("aext", aext, model_aext(3'd0));   // Idle selects slot 0
      next_drive();
   endtask

   // AR write, aext shows the selected slot while it lasts
   task automatic ar_write(input logic [1:0] lo, input logic idx,
                           input mbu_pkg::slot_idx_t irv);
      mbu_pkg::slot_idx_t slot;
      slot    = idx ? irv : {1'b0, lo};
      raddr   = IDLE;
      waddr   = {`MBU_UA_AR_HI, lo};
      ir_idx  = idx;
      ir      = irv;
      ibus_in = mbu_pkg::bank_t'($urandom);
      #1;
      check("war", mbu_pkg::bank_t'(war), 8'h01);
      check("aext", aext, model_aext(slot));
      next_drive();
      apply_idle();
      check_idle();
   endtask

   ////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////

   task automatic test_reset_default();
      fp_ram_rom = 1'b1;                    // ROM boot
      check_idle();
      check("aext", aext, 8'h80);
      read_unit(`MBU_UA_MBP, 3'd0, 8'h80);
      fp_ram_rom = 1'b0;                    // RAM boot
      check_idle();
      check("aext", aext, 8'h00);
      read_unit(`MBU_UA_MBP, 3'd0, 8'h00);
   endtask

   task automatic test_context_reg();
      mbu_pkg::bank_t v;
      for (int k = 0; k < 8; k++) begin
         v = mbu_pkg::bank_t'($urandom);
         // Write through one code, read through the other
         write_unit(k[0] ? `MBU_UA_CTX1 : `MBU_UA_CTX0, v, 3'd0);
         read_unit(k[0] ? `MBU_UA_CTX0 : `MBU_UA_CTX1, 3'd0, mbu_pkg::bank_t'(model_ctx));
      end
   endtask

   task automatic test_bank_access();
      mbu_pkg::slot_idx_t slot;
      fp_ram_rom = 1'b1;
      check_idle();                         // Still 80 before the enable
      write_unit(`MBU_UA_MBN, 8'h3C, 3'd0);
      check_idle();                         // Now slot 0 of the context
      for (int i = 0; i < `MBU_SLOTS; i++) begin
         slot = mbu_pkg::slot_idx_t'(i);
         write_unit(`MBU_UA_MBN, mbu_pkg::bank_t'($urandom), slot);
      end
      for (int i = 0; i < `MBU_SLOTS; i++) begin
         slot = mbu_pkg::slot_idx_t'(i);
         read_unit(`MBU_UA_MBN, slot, model_aext(slot));
      end
      read_unit(`MBU_UA_MBP, 3'd5, model_aext(3'd0));    // IR ignored
      write_unit(`MBU_UA_MBP, mbu_pkg::bank_t'($urandom), 3'd6);
      read_unit(`MBU_UA_MBN, 3'd0, model_aext(3'd0));
      read_unit(`MBU_UA_MBN, 3'd6, model_aext(3'd6));    // Slot 6 untouched
   endtask

   task automatic test_ar_select();
      for (int j = 0; j < 4; j++) begin
         ar_write(2'(j), 1'b0, mbu_pkg::slot_idx_t'($urandom));
      end
      for (int i = 0; i < `MBU_SLOTS; i++) begin
         ar_write(2'($urandom), 1'b1, mbu_pkg::slot_idx_t'(i));
      end
   endtask

   task automatic fill_context(input mbu_pkg::ctx_t c);
      write_unit(`MBU_UA_CTX0, mbu_pkg::bank_t'(c), 3'd0);
      for (int i = 0; i < `MBU_SLOTS; i++) begin
         write_unit(`MBU_UA_MBN, mbu_pkg::bank_t'($urandom), mbu_pkg::slot_idx_t'(i));
      end
   endtask

   task automatic test_context_isolation();
      mbu_pkg::ctx_t      ctx_a;
      mbu_pkg::ctx_t      ctx_b;
      mbu_pkg::slot_idx_t slot;
      ctx_a = mbu_pkg::ctx_t'($urandom);
      ctx_b = ctx_a ^ (mbu_pkg::ctx_t'($urandom) | mbu_pkg::ctx_t'(1));   // Never equal
      fill_context(ctx_a);
      fill_context(ctx_b);
      for (int k = 0; k < 6; k++) begin
         write_unit(k[0] ? `MBU_UA_CTX1 : `MBU_UA_CTX0,
                    mbu_pkg::bank_t'(k[0] ? ctx_b : ctx_a), 3'd0);
         read_unit(`MBU_UA_CTX0, 3'd0, mbu_pkg::bank_t'(model_ctx));
         for (int i = 0; i < `MBU_SLOTS; i++) begin
            slot = mbu_pkg::slot_idx_t'(i);
            read_unit(`MBU_UA_MBN, slot, model_aext(slot));
         end
         check_idle();
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Sequence
   ////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(78));
      clk4        = 1'b0;
      rst_n       = 1'b0;
      raddr       = IDLE;
      waddr       = IDLE;
      ibus_in     = '0;
      ir          = '0;
      ir_idx      = 1'b0;
      fp_ram_rom  = 1'b1;
      model_ctx   = '0;
      model_en    = 1'b0;
      cycle_count = 0;
      repeat (10) @(posedge clk4);
      #1;
      rst_n = 1'b1;
      test_reset_default();
      test_context_reg();
      test_bank_access();
      test_ar_select();
      test_context_isolation();
      $display("TEST PASS");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/mbu_pkg.sv
rtl/mbu_decoder.sv
rtl/mbu_bank_slot.sv
rtl/mbu_output_select.sv
rtl/mbu.sv
test/mbu_tb.sv

// ==== Makefile ====
# Verilator flow for the Memory Bank Unit testbench
TOP := mbu_tb

.PHONY: all lint clean

# Build, run, and pass only when the pass line shows up in the output
all:
	verilator --binary -f project.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | awk '{ print } /^TEST PASS$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module mbu

clean:
	rm -rf obj_dir
